// File: rrx_mem_pkg.sv
// ====================================================================
// Memory bus definitions for the memory hub
// Single-beat requests, in-order read responses, no write responses
// ====================================================================
package rrx_mem_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // Command engine is requester 0, framebuffer unit requester 1
    localparam int N_REQ = 2;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              write;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } mem_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
    } mem_rsp_t;

endpackage

// File: rrx_cmd_pkg.sv
// ====================================================================
// Command stream definitions for the memory hub
// Opcodes, header layout, framebuffer commands and output beats
// ====================================================================
package rrx_cmd_pkg;

    localparam int CMD_W = 32;
    localparam int OP_W  = 4;
    localparam int CNT_W = 16;

    localparam int CMD_FIFO_DEPTH = 4;
    localparam int RD_FIFO_DEPTH  = 4;

    typedef enum logic [OP_W-1:0] {
        OP_NOP   = 4'd0,
        OP_STORE = 4'd1,
        OP_LOAD  = 4'd2,
        OP_CLEAR = 4'd3,
        OP_SWAP  = 4'd4
    } cmd_op_e;

    // Header word: opcode in 31..28, word count in 15..0
    typedef struct packed {
        cmd_op_e                     op;
        logic [CMD_W-OP_W-CNT_W-1:0] rsvd;
        logic [CNT_W-1:0]            count;
    } cmd_hdr_t;

    typedef struct packed {
        logic [CMD_W-1:0] word;
    } cmd_beat_t;

    // swap set means SWAP, clear means CLEAR
    typedef struct packed {
        logic                          swap;
        logic [rrx_mem_pkg::ADDR_W-1:0] addr;
        logic [CNT_W-1:0]              count;
        logic [rrx_mem_pkg::DATA_W-1:0] fill;
    } fb_cmd_t;

    typedef struct packed {
        logic [rrx_mem_pkg::DATA_W-1:0] data;
        logic                          last;
    } fb_beat_t;

endpackage

// File: rrx_fifo.sv
// ====================================================================
// Synchronous FIFO with valid/ready on both sides
// Payload type is a parameter so one block serves several streams
// ====================================================================
`timescale 1ns/1ps

module rrx_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     aclk,
    input  logic     arst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int OCC_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [OCC_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = count != OCC_W'(DEPTH);
    assign out_valid = count != '0;
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge aclk)
    begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + OCC_W'(push) - OCC_W'(pop);
        end
    end

    // A refused word stays offered unchanged until the buffer takes it
    a_in_hold : assert property (@(posedge aclk) disable iff (!arst_n)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_data)));

endmodule

// File: rrx_cmd_engine.sv
// ====================================================================
// Command engine of the memory hub
// Decodes headers, runs STORE writes and LOAD reads on memory,
// hands CLEAR and SWAP to the framebuffer unit. LOAD reads are
// limited by credits so the read FIFO can never overflow.
// ====================================================================
`timescale 1ns/1ps

module rrx_cmd_engine (
    input  logic                   aclk,
    input  logic                   arst_n,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  rrx_cmd_pkg::cmd_beat_t cmd_data,
    output logic                   fbc_valid,
    input  logic                   fbc_ready,
    output rrx_cmd_pkg::fb_cmd_t   fbc_data,
    output logic                   req_valid,
    input  logic                   req_ready,
    output rrx_mem_pkg::mem_req_t  req_data,
    input  logic                   rsp_valid,
    output logic                   rsp_ready,
    input  rrx_mem_pkg::mem_rsp_t  rsp_data,
    output logic                   beat_valid,
    input  logic                   beat_ready,
    output rrx_cmd_pkg::fb_beat_t  beat_data,
    input  logic                   credit_return
);
    import rrx_mem_pkg::*;
    import rrx_cmd_pkg::*;

    localparam int CRD_W = $clog2(RD_FIFO_DEPTH + 1);

    typedef enum logic [2:0] {
        S_HDR,
        S_ADDR,
        S_STORE,
        S_LOAD,
        S_FILL,
        S_FBC,
        S_SWAIT
    } state_t;

    state_t            state;
    cmd_hdr_t          hdr;
    cmd_op_e           op_q;
    logic [CNT_W-1:0]  cnt_q;
    logic [CNT_W-1:0]  rsp_remain;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] fill_q;
    logic [CRD_W-1:0]  credits;
    logic              cmd_fire;
    logic              req_fire;
    logic              rsp_fire;

    assign hdr      = cmd_hdr_t'(cmd_data.word);
    assign cmd_fire = cmd_valid && cmd_ready;
    assign req_fire = req_valid && req_ready;
    assign rsp_fire = rsp_valid && rsp_ready;

    // Data words go straight to memory, so STORE accepts only with the bus
    assign cmd_ready = (state == S_HDR) || (state == S_ADDR) || (state == S_FILL)
                       || (state == S_STORE && req_ready);

    assign req_valid = (state == S_STORE && cmd_valid)
                       || (state == S_LOAD && cnt_q != '0
                           && credits < CRD_W'(RD_FIFO_DEPTH));
    assign req_data  = '{addr: addr_q,
                         write: state == S_STORE,
                         data: cmd_data.word,
                         strb: {STRB_W{state == S_STORE}}};

    assign fbc_valid = state == S_FBC;
    assign fbc_data  = '{swap: op_q == OP_SWAP, addr: addr_q, count: cnt_q, fill: fill_q};

    // Read data goes on to the read FIFO, last on the final word
    assign beat_valid = rsp_valid;
    assign rsp_ready  = beat_ready;
    assign beat_data  = '{data: rsp_data.data, last: rsp_remain == CNT_W'(1)};

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state      <= S_HDR;
            rsp_remain <= '0;
            credits    <= '0;
        end
        else
        begin
            credits <= credits + CRD_W'(req_fire && state == S_LOAD) - CRD_W'(credit_return);
            if (rsp_fire)
                rsp_remain <= rsp_remain - 1'b1;
            case (state)
                S_HDR:
                    // NOP and unknown opcodes are single words
                    if (cmd_fire && hdr.op inside {OP_STORE, OP_LOAD, OP_CLEAR, OP_SWAP})
                        state <= S_ADDR;
                S_ADDR:
                    if (cmd_fire)
                    begin
                        case (op_q)
                            OP_STORE: state <= (cnt_q == '0) ? S_HDR : S_STORE;
                            OP_LOAD:
                            begin
                                state      <= (cnt_q == '0) ? S_HDR : S_LOAD;
                                rsp_remain <= cnt_q;
                            end
                            OP_CLEAR: state <= S_FILL;
                            default:  state <= S_FBC;
                        endcase
                    end
                S_STORE:
                    if (req_fire && cnt_q == CNT_W'(1))
                        state <= S_HDR;
                S_LOAD:
                    if (rsp_fire && rsp_remain == CNT_W'(1))
                        state <= S_HDR;
                S_FILL:
                    if (cmd_fire)
                        state <= S_FBC;
                S_FBC:
                    // Nothing proceeds past a swap until the display confirms
                    if (fbc_ready)
                        state <= (op_q == OP_SWAP) ? S_SWAIT : S_HDR;
                default:
                    if (fbc_ready)
                        state <= S_HDR;
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (state == S_HDR && cmd_fire)
        begin
            op_q  <= hdr.op;
            cnt_q <= hdr.count;
        end
        if (state == S_ADDR && cmd_fire)
            addr_q <= cmd_data.word;
        if (state == S_FILL && cmd_fire)
            fill_q <= cmd_data.word;
        if (req_fire)
        begin
            addr_q <= addr_q + ADDR_W'(STRB_W);
            cnt_q  <= cnt_q - 1'b1;
        end
    end

    // Reads in flight plus buffered beats fit the read FIFO
    a_credit_bound : assert property (@(posedge aclk) disable iff (!arst_n)
        credits <= CRD_W'(RD_FIFO_DEPTH));

    // So a read response always finds room downstream
    a_rsp_room : assert property (@(posedge aclk) disable iff (!arst_n)
        rsp_valid |-> beat_ready);

endmodule

// File: rrx_fb_unit.sv
// ====================================================================
// Framebuffer unit
// CLEAR fills a region with one colour through its memory port,
// SWAP presents a new framebuffer address until the display confirms
// ====================================================================
`timescale 1ns/1ps

module rrx_fb_unit (
    input  logic                           aclk,
    input  logic                           arst_n,
    input  logic                           fbc_valid,
    output logic                           fbc_ready,
    input  rrx_cmd_pkg::fb_cmd_t           fbc_data,
    output logic                           req_valid,
    input  logic                           req_ready,
    output rrx_mem_pkg::mem_req_t          req_data,
    output logic                           swap_fb,
    output logic [rrx_mem_pkg::ADDR_W-1:0] fb_addr,
    input  logic                           fb_swapped
);
    import rrx_mem_pkg::*;
    import rrx_cmd_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_CLEAR,
        S_SWAP
    } state_t;

    state_t            state;
    logic [ADDR_W-1:0] addr_q;
    logic [CNT_W-1:0]  remain;
    logic [DATA_W-1:0] fill_q;
    logic              fbc_fire;
    logic              req_fire;

    assign fbc_ready = state == S_IDLE;
    assign fbc_fire  = fbc_valid && fbc_ready;
    assign req_valid = state == S_CLEAR;
    assign req_fire  = req_valid && req_ready;
    assign req_data  = '{addr: addr_q, write: 1'b1, data: fill_q, strb: {STRB_W{1'b1}}};
    assign swap_fb   = state == S_SWAP;

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state   <= S_IDLE;
            fb_addr <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (fbc_fire && fbc_data.swap)
                    begin
                        fb_addr <= fbc_data.addr;
                        state   <= S_SWAP;
                    end
                    else if (fbc_fire && fbc_data.count != '0)
                        state <= S_CLEAR;
                S_CLEAR:
                    if (req_fire && remain == CNT_W'(1))
                        state <= S_IDLE;
                default:
                    if (fb_swapped)
                        state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (fbc_fire)
        begin
            addr_q <= fbc_data.addr;
            remain <= fbc_data.count;
            fill_q <= fbc_data.fill;
        end
        else if (req_fire)
        begin
            addr_q <= addr_q + ADDR_W'(STRB_W);
            remain <= remain - 1'b1;
        end
    end

endmodule

// File: rrx_mem_arbiter.sv
// ====================================================================
// Round-robin arbiter onto the single memory request port
// Priority rotates after every transfer, a waiting grant is held
// ====================================================================
`timescale 1ns/1ps

module rrx_mem_arbiter (
    input  logic                                                  aclk,
    input  logic                                                  arst_n,
    input  logic                  [rrx_mem_pkg::N_REQ-1:0]        req_valid,
    output logic                  [rrx_mem_pkg::N_REQ-1:0]        req_ready,
    input  rrx_mem_pkg::mem_req_t [rrx_mem_pkg::N_REQ-1:0]        req_data,
    output logic                                                  mem_valid,
    input  logic                                                  mem_ready,
    output rrx_mem_pkg::mem_req_t                                 mem_data
);
    import rrx_mem_pkg::*;

    localparam int IDX_W = (N_REQ > 1) ? $clog2(N_REQ) : 1;

    logic [IDX_W-1:0] prio;
    logic [IDX_W-1:0] pick;
    logic [IDX_W-1:0] grant;
    logic [IDX_W-1:0] lock_idx;
    logic             locked;

    // First valid requester at or after the priority pointer
    always_comb
    begin
        pick = prio;
        for (int k = N_REQ - 1; k >= 0; k--)
        begin
            if (req_valid[(int'(prio) + k) % N_REQ])
                pick = IDX_W'((int'(prio) + k) % N_REQ);
        end
    end

    assign grant     = locked ? lock_idx : pick;
    assign mem_valid = req_valid[grant];
    assign mem_data  = req_data[grant];

    always_comb
    begin
        for (int i = 0; i < N_REQ; i++)
            req_ready[i] = mem_ready && (grant == IDX_W'(i));
    end

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            prio     <= '0;
            locked   <= 1'b0;
            lock_idx <= '0;
        end
        else if (mem_valid && mem_ready)
        begin
            prio   <= (grant == IDX_W'(N_REQ - 1)) ? '0 : grant + 1'b1;
            locked <= 1'b0;
        end
        else if (mem_valid)
        begin
            locked   <= 1'b1;
            lock_idx <= grant;
        end
    end

    // A granted request keeps the bus until it transfers
    a_grant_lock : assert property (@(posedge aclk) disable iff (!arst_n)
        (mem_valid && !mem_ready) |=> (grant == $past(grant)));

    // A stalled request stays on the bus unchanged
    a_hold_req : assert property (@(posedge aclk) disable iff (!arst_n)
        (mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_data)));

endmodule

// File: rrx_memhub.sv
// ====================================================================
// Memory hub top level
// Command FIFO, command engine, framebuffer unit, arbiter and the
// read FIFO that drives the framebuffer stream
// ====================================================================
`timescale 1ns/1ps

module rrx_memhub (
    input  logic                           aclk,
    input  logic                           arst_n,
    input  logic                           cmd_valid,
    output logic                           cmd_ready,
    input  rrx_cmd_pkg::cmd_beat_t         cmd_data,
    output logic                           fb_valid,
    input  logic                           fb_ready,
    output rrx_cmd_pkg::fb_beat_t          fb_data,
    output logic                           swap_fb,
    output logic [rrx_mem_pkg::ADDR_W-1:0] fb_addr,
    input  logic                           fb_swapped,
    output logic                           mem_req_valid,
    input  logic                           mem_req_ready,
    output rrx_mem_pkg::mem_req_t          mem_req_data,
    input  logic                           mem_rsp_valid,
    output logic                           mem_rsp_ready,
    input  rrx_mem_pkg::mem_rsp_t          mem_rsp_data
);
    import rrx_mem_pkg::*;
    import rrx_cmd_pkg::*;

    logic                  cq_valid;
    logic                  cq_ready;
    cmd_beat_t             cq_data;
    logic                  fbc_valid;
    logic                  fbc_ready;
    fb_cmd_t               fbc_data;
    logic [N_REQ-1:0]      arb_valid;
    logic [N_REQ-1:0]      arb_ready;
    mem_req_t [N_REQ-1:0]  arb_data;
    logic                  beat_valid;
    logic                  beat_ready;
    fb_beat_t              beat_data;
    logic                  credit_return;

    // Every beat leaving the read FIFO frees one read credit
    assign credit_return = fb_valid && fb_ready;

    rrx_fifo #(
        .payload_t(cmd_beat_t),
        .DEPTH(CMD_FIFO_DEPTH)
    ) u_cmd_fifo (
        .aclk(aclk),
        .arst_n(arst_n),
        .in_valid(cmd_valid),
        .in_ready(cmd_ready),
        .in_data(cmd_data),
        .out_valid(cq_valid),
        .out_ready(cq_ready),
        .out_data(cq_data)
    );

    rrx_cmd_engine u_engine (
        .aclk(aclk),
        .arst_n(arst_n),
        .cmd_valid(cq_valid),
        .cmd_ready(cq_ready),
        .cmd_data(cq_data),
        .fbc_valid(fbc_valid),
        .fbc_ready(fbc_ready),
        .fbc_data(fbc_data),
        .req_valid(arb_valid[0]),
        .req_ready(arb_ready[0]),
        .req_data(arb_data[0]),
        .rsp_valid(mem_rsp_valid),
        .rsp_ready(mem_rsp_ready),
        .rsp_data(mem_rsp_data),
        .beat_valid(beat_valid),
        .beat_ready(beat_ready),
        .beat_data(beat_data),
        .credit_return(credit_return)
    );

    rrx_fb_unit u_fb_unit (
        .aclk(aclk),
        .arst_n(arst_n),
        .fbc_valid(fbc_valid),
        .fbc_ready(fbc_ready),
        .fbc_data(fbc_data),
        .req_valid(arb_valid[1]),
        .req_ready(arb_ready[1]),
        .req_data(arb_data[1]),
        .swap_fb(swap_fb),
        .fb_addr(fb_addr),
        .fb_swapped(fb_swapped)
    );

    rrx_mem_arbiter u_arbiter (
        .aclk(aclk),
        .arst_n(arst_n),
        .req_valid(arb_valid),
        .req_ready(arb_ready),
        .req_data(arb_data),
        .mem_valid(mem_req_valid),
        .mem_ready(mem_req_ready),
        .mem_data(mem_req_data)
    );

    rrx_fifo #(
        .payload_t(fb_beat_t),
        .DEPTH(RD_FIFO_DEPTH)
    ) u_rd_fifo (
        .aclk(aclk),
        .arst_n(arst_n),
        .in_valid(beat_valid),
        .in_ready(beat_ready),
        .in_data(beat_data),
        .out_valid(fb_valid),
        .out_ready(fb_ready),
        .out_data(fb_data)
    );

endmodule

// File: tb_rrx_mem_model.sv
// ======================================================================
// Behavioural memory for the memory hub testbench
// Random request ready, reads answered in order after random delays
// ======================================================================
`timescale 1ns/1ps

module tb_rrx_mem_model (
    input  logic                  aclk,
    input  logic                  arst_n,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  rrx_mem_pkg::mem_req_t req_data,
    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output rrx_mem_pkg::mem_rsp_t rsp_data
);
    import rrx_mem_pkg::*;

    localparam int DRIVE_NS = 5;

    logic [DATA_W-1:0] words [logic [ADDR_W-1:0]];
    logic [DATA_W-1:0] rd_data_q [$];
    int                rd_due_q [$];
    int                cycle;
    int                last_due;
    int                due;

    // Unwritten words read back a pattern of their own address
    function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] a);
        return words.exists(a) ? words[a] : (a ^ 32'h5A5A_A5A5);
    endfunction

    task automatic write_word(input mem_req_t r);
        logic [DATA_W-1:0] w;
        w = read_word(r.addr);
        for (int b = 0; b < STRB_W; b++)
        begin
            if (r.strb[b])
                w[8*b +: 8] = r.data[8*b +: 8];
        end
        words[r.addr] = w;
    endtask

    initial
    begin
        req_ready = 1'b0;
        rsp_valid = 1'b0;
        rsp_data  = '0;
        cycle     = 0;
        last_due  = 0;
        forever
        begin
            @(posedge aclk);
            cycle++;
            if (arst_n && rsp_valid && rsp_ready)
            begin
                void'(rd_data_q.pop_front());
                void'(rd_due_q.pop_front());
            end
            if (arst_n && req_valid && req_ready)
            begin
                if (req_data.write)
                    write_word(req_data);
                else
                begin
                    // In order, so a response is never due before the one ahead
                    due      = cycle + int'($urandom_range(4, 1));
                    last_due = (due > last_due) ? due : last_due;
                    rd_data_q.push_back(read_word(req_data.addr));
                    rd_due_q.push_back(last_due);
                end
            end
            #(DRIVE_NS);
            req_ready     = arst_n && ($urandom_range(3) != 0);
            rsp_valid     = (rd_due_q.size() != 0) && (rd_due_q[0] <= cycle);
            rsp_data.data = rsp_valid ? rd_data_q[0] : '0;
        end
    end

endmodule

// File: tb_rrx_memhub.sv
// ======================================================================
// Testbench of the memory hub
// Drives STORE, LOAD, CLEAR and SWAP commands, checks the framebuffer
// stream, memory writes and the swap handshake with assertions
// ======================================================================
`timescale 1ns/1ps

module tb_rrx_memhub;
    import rrx_mem_pkg::*;
    import rrx_cmd_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_NS   = 5;
    localparam int SB_SIZE    = 256;
    localparam int WAIT_LIMIT = 400;
    // Cycle budget of each test, summed for the watchdog
    localparam int RUN_CYCLES = 40 + 250 + 250 + 500 + 200 + 500;
    localparam int MARGIN     = 3;

    logic              aclk;
    logic              arst_n;
    logic              cmd_valid;
    logic              cmd_ready;
    cmd_beat_t         cmd_data;
    logic              fb_valid;
    logic              fb_ready;
    fb_beat_t          fb_data;
    logic              swap_fb;
    logic [ADDR_W-1:0] fb_addr;
    logic              fb_swapped;
    logic              mem_req_valid;
    logic              mem_req_ready;
    mem_req_t          mem_req_data;
    logic              mem_rsp_valid;
    logic              mem_rsp_ready;
    mem_rsp_t          mem_rsp_data;

    // Scoreboard of expected output beats, in order
    fb_beat_t          sb_beats [SB_SIZE];
    int                sb_wr;
    int                sb_rd;
    logic [DATA_W-1:0] shadow [logic [ADDR_W-1:0]];
    int                write_cnt;
    int                exp_writes;
    logic              cmd_seen;
    logic              rand_out;
    logic [ADDR_W-1:0] swap_addr;
    int                errors;
    int                errors_at_start;
    int                tests_run;
    int                tests_failed;

    rrx_memhub dut (
        .aclk(aclk),
        .arst_n(arst_n),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .cmd_data(cmd_data),
        .fb_valid(fb_valid),
        .fb_ready(fb_ready),
        .fb_data(fb_data),
        .swap_fb(swap_fb),
        .fb_addr(fb_addr),
        .fb_swapped(fb_swapped),
        .mem_req_valid(mem_req_valid),
        .mem_req_ready(mem_req_ready),
        .mem_req_data(mem_req_data),
        .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp_ready(mem_rsp_ready),
        .mem_rsp_data(mem_rsp_data)
    );

    tb_rrx_mem_model u_mem (
        .aclk(aclk),
        .arst_n(arst_n),
        .req_valid(mem_req_valid),
        .req_ready(mem_req_ready),
        .req_data(mem_req_data),
        .rsp_valid(mem_rsp_valid),
        .rsp_ready(mem_rsp_ready),
        .rsp_data(mem_rsp_data)
    );

    initial
    begin
        aclk = 1'b0;
        forever
            #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    task automatic flag_mismatch(input string msg);
        errors++;
        $display("MISMATCH at %0t: %s", $time, msg);
    endtask

    task automatic flag_failure(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // A write must hit a word that some STORE or CLEAR set to that value
    function automatic logic write_expected(input mem_req_t r);
        return shadow.exists(r.addr) && (shadow[r.addr] == r.data);
    endfunction

    function automatic logic [CMD_W-1:0] header(input cmd_op_e op, input int n);
        return {op, 12'h000, n[15:0]};
    endfunction

    always @(posedge aclk)
    begin
        #(DRIVE_NS);
        fb_ready = rand_out ? ($urandom_range(1) == 1) : 1'b1;
    end

    always @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sb_rd     <= 0;
            write_cnt <= 0;
            cmd_seen  <= 1'b0;
        end
        else
        begin
            if (fb_valid && fb_ready)
                sb_rd <= sb_rd + 1;
            if (mem_req_valid && mem_req_ready && mem_req_data.write)
                write_cnt <= write_cnt + 1;
            if (cmd_valid && cmd_ready)
                cmd_seen <= 1'b1;
        end
    end

    a_idle : assert property (@(posedge aclk) disable iff (!arst_n)
        !cmd_seen |-> !(fb_valid || mem_req_valid || swap_fb))
        else flag_mismatch("output active before any command");

    a_beat : assert property (@(posedge aclk) disable iff (!arst_n)
        (fb_valid && fb_ready) |-> (sb_rd < sb_wr && fb_data == sb_beats[sb_rd]))
        else flag_mismatch($sformatf("beat %0d got data %h last %0b", $sampled(sb_rd),
                                     $sampled(fb_data.data), $sampled(fb_data.last)));

    a_out_hold : assert property (@(posedge aclk) disable iff (!arst_n)
        (fb_valid && !fb_ready) |=> (fb_valid && $stable(fb_data)))
        else flag_mismatch("stalled output beat changed");

    a_write : assert property (@(posedge aclk) disable iff (!arst_n)
        (mem_req_valid && mem_req_ready && mem_req_data.write) |-> write_expected(mem_req_data))
        else flag_mismatch($sformatf("unexpected write of %h to %h",
                                     $sampled(mem_req_data.data), $sampled(mem_req_data.addr)));

    a_no_write_swap : assert property (@(posedge aclk) disable iff (!arst_n)
        swap_fb |-> !(mem_req_valid && mem_req_ready && mem_req_data.write))
        else flag_mismatch("memory write while swap_fb is high");

    a_swap_addr : assert property (@(posedge aclk) disable iff (!arst_n)
        swap_fb |-> (fb_addr == swap_addr))
        else flag_mismatch($sformatf("fb_addr %h during swap", $sampled(fb_addr)));

    a_swap_hold : assert property (@(posedge aclk) disable iff (!arst_n)
        (swap_fb && !fb_swapped) |=> swap_fb)
        else flag_mismatch("swap_fb fell before fb_swapped");

    a_swap_fall : assert property (@(posedge aclk) disable iff (!arst_n)
        (swap_fb && fb_swapped) |=> !swap_fb)
        else flag_mismatch("swap_fb still high after fb_swapped");

    task automatic idle(input int n);
        repeat (n) @(posedge aclk);
        #(DRIVE_NS);
    endtask

    task automatic send_word(input logic [CMD_W-1:0] w);
        int   waited;
        logic taken;
        waited        = 0;
        taken         = 1'b0;
        cmd_valid     = 1'b1;
        cmd_data.word = w;
        while (!taken && waited < WAIT_LIMIT)
        begin
            @(posedge aclk);
            taken = cmd_ready;
            waited++;
            #(DRIVE_NS);
        end
        cmd_valid = 1'b0;
        if (!taken)
            flag_failure("command word was never accepted");
    endtask

    task automatic store(input logic [ADDR_W-1:0] base, input int n);
        logic [DATA_W-1:0] w;
        send_word(header(OP_STORE, n));
        send_word(base);
        for (int i = 0; i < n; i++)
        begin
            w = $urandom;
            shadow[base + ADDR_W'(i * STRB_W)] = w;
            send_word(w);
        end
        exp_writes += n;
    endtask

    task automatic clear(input logic [ADDR_W-1:0] base, input int n,
                         input logic [DATA_W-1:0] fill);
        for (int i = 0; i < n; i++)
            shadow[base + ADDR_W'(i * STRB_W)] = fill;
        send_word(header(OP_CLEAR, n));
        send_word(base);
        send_word(fill);
        exp_writes += n;
    endtask

    // Expected beats follow the shadow image, last only on beat n
    task automatic load(input logic [ADDR_W-1:0] base, input int n);
        for (int i = 0; i < n; i++)
        begin
            sb_beats[sb_wr] = '{data: shadow[base + ADDR_W'(i * STRB_W)], last: i == n - 1};
            sb_wr++;
        end
        send_word(header(OP_LOAD, n));
        send_word(base);
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while ((write_cnt != exp_writes || sb_rd != sb_wr) && waited < WAIT_LIMIT)
        begin
            idle(1);
            waited++;
        end
        if (write_cnt != exp_writes)
            flag_failure($sformatf("only %0d of %0d memory writes seen", write_cnt, exp_writes));
        if (sb_rd != sb_wr)
            flag_failure($sformatf("only %0d of %0d output beats seen", sb_rd, sb_wr));
    endtask

    task automatic wait_swap(input logic level);
        int waited;
        waited = 0;
        while (swap_fb !== level && waited < WAIT_LIMIT)
        begin
            idle(1);
            waited++;
        end
        if (swap_fb !== level)
            flag_failure($sformatf("swap_fb never went to %0b", level));
    endtask

    task automatic end_test(input string name);
        int n;
        n = errors - errors_at_start;
        tests_run++;
        if (n != 0)
            tests_failed++;
        $display("test %0d %s: %s (%0d errors)", tests_run, name, (n == 0) ? "ok" : "failed", n);
        errors_at_start = errors;
    endtask

    initial
    begin
        void'($urandom(73));
        arst_n          = 1'b0;
        cmd_valid       = 1'b0;
        cmd_data        = '0;
        fb_ready        = 1'b1;
        fb_swapped      = 1'b0;
        rand_out        = 1'b0;
        swap_addr       = '0;
        sb_wr           = 0;
        exp_writes      = 0;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        idle(2);
        arst_n = 1'b1;

        idle(10);
        end_test("reset idle");

        store(32'h0000_1000, 8);
        wait_drained();
        load(32'h0000_1000, 8);
        wait_drained();
        end_test("store then load");

        clear(32'h0000_2000, 6, 32'hC0FF_EE00);
        wait_drained();
        load(32'h0000_2000, 6);
        wait_drained();
        end_test("clear then load");

        // Clear first so the framebuffer unit runs while the store issues
        clear(32'h0000_4000, 8, 32'h00FF_00FF);
        store(32'h0000_3000, 8);
        wait_drained();
        load(32'h0000_3000, 8);
        load(32'h0000_4000, 8);
        wait_drained();
        end_test("store and clear compete");

        swap_addr = 32'h8000_0000;
        send_word(header(OP_SWAP, 0));
        send_word(swap_addr);
        store(32'h0000_5000, 2);
        wait_swap(1'b1);
        idle(6);
        fb_swapped = 1'b1;
        wait_swap(1'b0);
        fb_swapped = 1'b0;
        wait_drained();
        load(32'h0000_5000, 2);
        wait_drained();
        end_test("swap handshake");

        rand_out = 1'b1;
        store(32'h0000_6000, 12);
        wait_drained();
        send_word(header(OP_NOP, 0));
        load(32'h0000_6000, 12);
        wait_drained();
        rand_out = 1'b0;
        end_test("load with back-pressure");

        $display("tests %0d, failed %0d, beats checked %0d, errors %0d",
                 tests_run, tests_failed, sb_rd, errors);
        if (errors == 0 && tests_failed == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        #(RUN_CYCLES * MARGIN * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", RUN_CYCLES * MARGIN);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: rrx_memhub.f
rrx_mem_pkg.sv
rrx_cmd_pkg.sv
rrx_fifo.sv
rrx_cmd_engine.sv
rrx_fb_unit.sv
rrx_mem_arbiter.sv
rrx_memhub.sv
tb_rrx_mem_model.sv
tb_rrx_memhub.sv

// File: Makefile
# Verilator build and run of the memory hub testbench

VERILATOR ?= verilator
TOP       ?= tb_rrx_memhub
FLIST     ?= rrx_memhub.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

test: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
